// ==== verilog/sha_pkg.sv ====
`default_nettype none

package sha_pkg;

  // Working registers a..h. The first member sits in the upper word.
  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] f;
    logic [31:0] g;
    logic [31:0] h;
  } hash_words_t;

  // The same 256 bits seen as registers or as one digest word.
  typedef union packed {
    hash_words_t  words;
    logic [255:0] digest;
  } hash_state_u;

  // Last sixteen schedule words. Element 0 is the oldest one.
  typedef logic [15:0][31:0] msg_hist_t;

  localparam int PIPE_LATENCY = 129; // Issue to result, in clock cycles.

  localparam logic [0:63][31:0] SHA_K = {
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  localparam hash_state_u SHA_H0 = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  function automatic logic [31:0] rotr(logic [31:0] x, int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // One compression round with round constant k and schedule word w.
  function automatic hash_state_u sha_round(hash_state_u s, logic [31:0] k, logic [31:0] w);
    logic [31:0] s1;
    logic [31:0] ch;
    logic [31:0] t1;
    logic [31:0] s0;
    logic [31:0] maj;
    hash_state_u r;
    s1  = rotr(s.words.e, 6) ^ rotr(s.words.e, 11) ^ rotr(s.words.e, 25);
    ch  = (s.words.e & s.words.f) ^ (~s.words.e & s.words.g);
    t1  = s.words.h + s1 + ch + k + w;
    s0  = rotr(s.words.a, 2) ^ rotr(s.words.a, 13) ^ rotr(s.words.a, 22);
    maj = (s.words.a & s.words.b) ^ (s.words.a & s.words.c) ^ (s.words.b & s.words.c);
    r.words.a = t1 + s0 + maj;
    r.words.b = s.words.a;
    r.words.c = s.words.b;
    r.words.d = s.words.c;
    r.words.e = s.words.d + t1;
    r.words.f = s.words.e;
    r.words.g = s.words.f;
    r.words.h = s.words.g;
    return r;
  endfunction

  // Next schedule word from the sixteen words before it.
  function automatic logic [31:0] sha_expand(msg_hist_t w);
    logic [31:0] s0;
    logic [31:0] s1;
    s0 = rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3);
    s1 = rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10);
    return w[0] + s0 + w[9] + s1;
  endfunction

  function automatic hash_state_u sha_add_state(hash_state_u x, hash_state_u y);
    hash_state_u r;
    r.words.a = x.words.a + y.words.a;
    r.words.b = x.words.b + y.words.b;
    r.words.c = x.words.c + y.words.c;
    r.words.d = x.words.d + y.words.d;
    r.words.e = x.words.e + y.words.e;
    r.words.f = x.words.f + y.words.f;
    r.words.g = x.words.g + y.words.g;
    r.words.h = x.words.h + y.words.h;
    return r;
  endfunction

endpackage : sha_pkg

`default_nettype wire

// ==== verilog/sha_stage_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface sha_stage_if;
  import sha_pkg::*;

  logic        valid;    // Stage holds an item.
  logic        newblock; // First item of a job.
  logic [31:0] nonce;
  hash_state_u state;
  msg_hist_t   w;

  modport source (output valid, newblock, nonce, state, w);
  modport sink   (input valid, newblock, nonce, state, w);

endinterface : sha_stage_if

`default_nettype wire

// ==== verilog/sha_round_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_round_stage #(
  parameter logic [31:0] K      = 32'h0,
  parameter bit          EXPAND = 1'b0
) (
  input  logic        clk,
  input  logic        arst_n_i,
  sha_stage_if.sink   up,
  sha_stage_if.source dn
);
  import sha_pkg::*;

  logic [31:0] w_cur;      // Schedule word used by this round.
  msg_hist_t   w_next;
  hash_state_u state_next;

  // The first sixteen rounds walk the history once around, so that the
  // expanding rounds find W[t-16] in element 0 again.
  always_comb begin
    if (EXPAND) begin
      w_cur  = sha_expand(up.w);
      w_next = {w_cur, up.w[15:1]}; // Oldest word drops out.
    end else begin
      w_cur  = up.w[0];
      w_next = {up.w[0], up.w[15:1]}; // Current word goes to the back.
    end
  end

  assign state_next = sha_round(up.state, K, w_cur);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dn.valid    <= 1'b0;
      dn.newblock <= 1'b0;
    end else begin
      dn.valid    <= up.valid;
      dn.newblock <= up.newblock;
    end
  end

  always_ff @(posedge clk) begin
    dn.nonce <= up.nonce;
    dn.state <= state_next;
    dn.w     <= w_next;
  end

endmodule : sha_round_stage

`default_nettype wire

// ==== verilog/sha_job_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_job_regs (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 job_load_i,
  input  sha_pkg::hash_state_u midstate_i,
  input  logic [31:0]          merkle_tail_i,
  input  logic [31:0]          time_i,
  input  logic [31:0]          bits_i,
  input  logic [31:0]          nonce_start_i,
  input  logic [31:0]          nonce_count_i,
  sha_stage_if.source          issue,
  output sha_pkg::hash_state_u mid_o
);
  import sha_pkg::*;

  hash_state_u mid_q;
  logic [31:0] tail_q;
  logic [31:0] time_q;
  logic [31:0] bits_q;
  logic [31:0] nonce_q;
  logic [31:0] remain_q; // Nonces still to issue.
  logic        first_q;  // Next issue is the first of its job.
  logic        issuing;

  assign issuing = (remain_q != 32'd0);

  // A load overrides whatever is still left of the running job.
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      remain_q <= 32'd0;
      first_q  <= 1'b0;
    end else if (job_load_i) begin
      remain_q <= nonce_count_i;
      first_q  <= 1'b1;
    end else if (issuing) begin
      remain_q <= remain_q - 32'd1;
      first_q  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (job_load_i) begin
      mid_q   <= midstate_i;
      tail_q  <= merkle_tail_i;
      time_q  <= time_i;
      bits_q  <= bits_i;
      nonce_q <= nonce_start_i;
    end else if (issuing) begin
      nonce_q <= nonce_q + 32'd1;
    end
  end

  assign issue.valid    = issuing;
  assign issue.newblock = issuing & first_q;
  assign issue.nonce    = nonce_q;
  assign issue.state    = mid_q;
  // Second header chunk, padded to 640 bits of message.
  assign issue.w = {32'd640, {10{32'h0}}, 32'h8000_0000, nonce_q, bits_q, time_q, tail_q};
  assign mid_o   = mid_q;

endmodule : sha_job_regs

`default_nettype wire

// ==== verilog/sha_state_delay.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_state_delay #(
  parameter int DELAY = 64 // Total latency, at least 2.
) (
  input  logic                 clk,
  input  logic                 newblock_i,
  input  sha_pkg::hash_state_u state_i,
  output sha_pkg::hash_state_u state_o
);
  import sha_pkg::*;

  // DELAY-1 chain entries plus the output register give DELAY cycles.
  logic        mark_q  [DELAY-1];
  hash_state_u state_q [DELAY-1];

  always_ff @(posedge clk) begin
    mark_q[0]  <= newblock_i;
    state_q[0] <= state_i;
    for (int i = 1; i < DELAY - 1; i++) begin
      mark_q[i]  <= mark_q[i-1];
      state_q[i] <= state_q[i-1];
    end
    // Held until the next job's first item arrives at the far end.
    if (mark_q[DELAY-2]) begin
      state_o <= state_q[DELAY-2];
    end
  end

endmodule : sha_state_delay

`default_nettype wire

// ==== verilog/sha_pad_hash.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_pad_hash (
  input  logic                 clk,
  input  logic                 arst_n_i,
  sha_stage_if.sink            up,
  input  sha_pkg::hash_state_u mid_i,
  sha_stage_if.source          dn
);
  import sha_pkg::*;

  hash_state_u digest; // First SHA-256 result.

  assign digest = sha_add_state(up.state, mid_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dn.valid    <= 1'b0;
      dn.newblock <= 1'b0;
    end else begin
      dn.valid    <= up.valid;
      dn.newblock <= up.newblock;
    end
  end

  always_ff @(posedge clk) begin
    dn.nonce <= up.nonce;
    dn.state <= SHA_H0; // Second hash starts from the initial value.
    dn.w     <= {32'd256, {6{32'h0}}, 32'h8000_0000,
                 digest.words.h, digest.words.g, digest.words.f, digest.words.e,
                 digest.words.d, digest.words.c, digest.words.b, digest.words.a};
  end

endmodule : sha_pad_hash

`default_nettype wire

// ==== verilog/sha_double_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_double_core (
  input  logic                 clk,
  input  logic                 arst_n_i,
  sha_stage_if.sink            issue,
  input  sha_pkg::hash_state_u mid_i,
  output logic                 hash_valid_o,
  output logic                 hash_newblock_o,
  output logic [31:0]          nonce_o,
  output sha_pkg::hash_state_u hash_o
);
  import sha_pkg::*;

  sha_stage_if h1_if [1:64] (); // Outputs of the first-hash rounds.
  sha_stage_if h2_if [0:64] (); // Pad stage output and second-hash rounds.

  hash_state_u mid_dly; // Midstate that belongs to the item at h1_if[64].

  sha_state_delay #(
    .DELAY(64)
  ) u_mid_delay (
    .clk,
    .newblock_i(issue.newblock),
    .state_i   (mid_i),
    .state_o   (mid_dly)
  );

  for (genvar i = 0; i < 64; i++) begin : g_hash1
    if (i == 0) begin : g_first
      sha_round_stage #(
        .K     (SHA_K[i]),
        .EXPAND(1'b0)
      ) u_round (
        .clk,
        .arst_n_i,
        .up(issue),
        .dn(h1_if[1])
      );
    end else begin : g_rest
      sha_round_stage #(
        .K     (SHA_K[i]),
        .EXPAND(i >= 16)
      ) u_round (
        .clk,
        .arst_n_i,
        .up(h1_if[i]),
        .dn(h1_if[i+1])
      );
    end
  end

  sha_pad_hash u_pad (
    .clk,
    .arst_n_i,
    .up   (h1_if[64]),
    .mid_i(mid_dly),
    .dn   (h2_if[0])
  );

  for (genvar i = 0; i < 64; i++) begin : g_hash2
    sha_round_stage #(
      .K     (SHA_K[i]),
      .EXPAND(i >= 16)
    ) u_round (
      .clk,
      .arst_n_i,
      .up(h2_if[i]),
      .dn(h2_if[i+1])
    );
  end

  // Final add of the second hash stays combinational.
  assign hash_o          = sha_add_state(h2_if[64].state, SHA_H0);
  assign hash_valid_o    = h2_if[64].valid;
  assign hash_newblock_o = h2_if[64].newblock;
  assign nonce_o         = h2_if[64].nonce;

endmodule : sha_double_core

`default_nettype wire

// ==== verilog/sha_miner_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_miner_top (
  input  logic          clk,
  input  logic          arst_n_i,
  input  logic          job_load_i,
  input  logic [255:0]  midstate_i,
  input  logic [31:0]   merkle_tail_i,
  input  logic [31:0]   time_i,
  input  logic [31:0]   bits_i,
  input  logic [31:0]   nonce_start_i,
  input  logic [31:0]   nonce_count_i,
  output logic          hash_valid_o,
  output logic          hash_newblock_o,
  output logic [31:0]   nonce_o,
  output logic [255:0]  hash_o
);
  import sha_pkg::*;

  hash_state_u midstate; // Host word seen as a hash state.
  hash_state_u mid;
  hash_state_u hash;

  sha_stage_if issue_if ();

  assign midstate.digest = midstate_i;
  assign hash_o          = hash.digest; // Word a ends up in bits 255:224.

  sha_job_regs u_job_regs (
    .clk,
    .arst_n_i,
    .job_load_i,
    .midstate_i(midstate),
    .merkle_tail_i,
    .time_i,
    .bits_i,
    .nonce_start_i,
    .nonce_count_i,
    .issue     (issue_if),
    .mid_o     (mid)
  );

  sha_double_core u_core (
    .clk,
    .arst_n_i,
    .issue(issue_if),
    .mid_i(mid),
    .hash_valid_o,
    .hash_newblock_o,
    .nonce_o,
    .hash_o(hash)
  );

endmodule : sha_miner_top

`default_nettype wire

// ==== bench/sha_miner_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha_miner_props (
  input logic        clk,
  input logic        arst_n_i,
  input logic        job_load_i,
  input logic [31:0] nonce_count_i,
  input logic        hash_valid_o,
  input logic        hash_newblock_o
);

  // Sampled on the falling edge, once the reset has reached the last stage.
  valid_low_in_reset : assert property (@(negedge clk) !arst_n_i |-> !hash_valid_o)
    else $error("hash_valid_o high while arst_n_i is low");

  // Load at one edge, first issue in the next cycle, result 129 cycles on.
  first_result_latency : assert property (
    @(posedge clk) disable iff (!arst_n_i)
      (job_load_i && nonce_count_i != 32'd0) |-> ##130 (hash_valid_o && hash_newblock_o)
  ) else $error("first result of a job did not arrive 129 cycles after its issue");

  newblock_needs_valid : assert property (
    @(posedge clk) disable iff (!arst_n_i) hash_newblock_o |-> hash_valid_o
  ) else $error("hash_newblock_o set without hash_valid_o");

endmodule : sha_miner_props

bind sha_miner_top sha_miner_props u_props (.*);

`default_nettype wire

// ==== bench/tb_sha_miner.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_sha_miner;

  localparam int N_ROWS      = 4;
  localparam int LATENCY     = 129; // Issue cycle to result cycle.
  localparam int MAX_GAP     = 7;
  localparam int IDLE_CYCLES = 10;

  typedef struct packed {
    logic [511:0] chunk;  // First 64 header bytes as big-endian words.
    logic [31:0]  tail;
    logic [31:0]  time_w;
    logic [31:0]  bits;
    logic [31:0]  start;
    logic [31:0]  count;
    logic [31:0]  hit;    // Result index whose hash is known.
    logic [31:0]  reload; // Cycles until the next load cuts this job, 0 for none.
    logic [255:0] hash;
  } job_row_t;

  typedef struct packed {
    logic [31:0]  row;
    logic         last;
    logic         chk;
    logic         nb;
    logic [31:0]  nonce;
    logic [31:0]  cyc;
    logic [255:0] hash;
  } result_t;

  localparam logic [255:0] IV =
    256'h6a09e667_bb67ae85_3c6ef372_a54ff53a_510e527f_9b05688c_1f83d9ab_5be0cd19;

  localparam logic [2047:0] ROUND_K = {
    256'h428a2f98_71374491_b5c0fbcf_e9b5dba5_3956c25b_59f111f1_923f82a4_ab1c5ed5,
    256'hd807aa98_12835b01_243185be_550c7dc3_72be5d74_80deb1fe_9bdc06a7_c19bf174,
    256'he49b69c1_efbe4786_0fc19dc6_240ca1cc_2de92c6f_4a7484aa_5cb0a9dc_76f988da,
    256'h983e5152_a831c66d_b00327c8_bf597fc7_c6e00bf3_d5a79147_06ca6351_14292967,
    256'h27b70a85_2e1b2138_4d2c6dfc_53380d13_650a7354_766a0abb_81c2c92e_92722c85,
    256'ha2bfe8a1_a81a664b_c24b8b70_c76c51a3_d192e819_d6990624_f40e3585_106aa070,
    256'h19a4c116_1e376c08_2748774c_34b0bcb5_391c0cb3_4ed8aa4a_5b9cca4f_682e6ff3,
    256'h748f82ee_78a5636f_84c87814_8cc70208_90befffa_a4506ceb_bef9a3f7_c67178f2
  };

  // Version, previous block hash and the head of the merkle root.
  localparam logic [511:0] GEN_CHUNK = {32'h01000000, 256'h0,
    224'h3ba3edfd_7a7b12b2_7ac72c3e_67768f61_7fc81bc3_888a5132_3a9fb8aa};
  localparam logic [511:0] BLK1_CHUNK = {32'h01000000,
    256'h6fe28c0a_b6f1b372_c1a6a246_ae63f74f_931e8365_e15a089c_68d61900_00000000,
    224'h982051fd_1e4ba744_bbbe680e_1fee1467_7ba1a3c3_540bf7b1_cdb606e8};
  localparam logic [255:0] GEN_HASH =
    256'h6fe28c0a_b6f1b372_c1a6a246_ae63f74f_931e8365_e15a089c_68d61900_00000000;
  localparam logic [255:0] BLK1_HASH =
    256'h4860eb18_bf1b1620_e37e9490_fc8a4275_14416fd7_5159ab86_688e9a83_00000000;

  logic         clk;
  logic         arst_n_i;
  logic         job_load_i;
  logic [255:0] midstate_i;
  logic [31:0]  merkle_tail_i;
  logic [31:0]  time_i;
  logic [31:0]  bits_i;
  logic [31:0]  nonce_start_i;
  logic [31:0]  nonce_count_i;
  logic         hash_valid_o;
  logic         hash_newblock_o;
  logic [31:0]  nonce_o;
  logic [255:0] hash_o;

  job_row_t    jobs [0:N_ROWS-1];
  result_t     exp_q [$];
  result_t     head;
  int          row_err [0:N_ROWS-1];
  int          err_cnt;
  int          tests_ok;
  int          cycle_limit;
  logic [31:0] cyc;

  sha_miner_top u_sha_miner_top (
    .clk,
    .arst_n_i,
    .job_load_i,
    .midstate_i,
    .merkle_tail_i,
    .time_i,
    .bits_i,
    .nonce_start_i,
    .nonce_count_i,
    .hash_valid_o,
    .hash_newblock_o,
    .nonce_o,
    .hash_o
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] ror32(logic [31:0] x, int n);
    logic [63:0] x2;
    x2 = {x, x} >> n;
    return x2[31:0];
  endfunction

  // Reference SHA-256 compression, used to build the midstate of a header.
  function automatic logic [255:0] compress_chunk(logic [255:0] iv, logic [511:0] blk);
    logic [31:0]  w [0:63];
    logic [31:0]  v [0:7];
    logic [31:0]  t1;
    logic [31:0]  t2;
    logic [31:0]  sg0;
    logic [31:0]  sg1;
    logic [255:0] out;
    for (int t = 0; t < 64; t++) begin
      if (t < 16) begin
        w[t] = blk[511 - 32*t -: 32];
      end else begin
        sg0  = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
        sg1  = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + sg0 + w[t-7] + sg1;
      end
    end
    for (int i = 0; i < 8; i++) v[i] = iv[255 - 32*i -: 32];
    for (int t = 0; t < 64; t++) begin
      sg1 = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
      t1  = v[7] + sg1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + ROUND_K[2047 - 32*t -: 32] + w[t];
      sg0 = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
      t2  = sg0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      for (int i = 7; i > 0; i--) v[i] = v[i-1];
      v[4] = v[4] + t1;
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) out[255 - 32*i -: 32] = iv[255 - 32*i -: 32] + v[i];
    return out;
  endfunction

  // The load is taken one edge after it is driven, the first issue follows it.
  task automatic expect_result(input int r, input int k, input int n_res,
                               input logic [31:0] load_cyc);
    result_t e;
    e.row   = r;
    e.last  = (k == n_res - 1);
    e.chk   = (k == jobs[r].hit);
    e.nb    = (k == 0);
    e.nonce = jobs[r].start + k;
    e.cyc   = load_cyc + LATENCY + 1 + k;
    e.hash  = jobs[r].hash;
    exp_q.push_back(e);
  endtask

  task automatic note_error(input int r);
    err_cnt++;
    row_err[r]++;
  endtask

  task automatic close_row(input result_t e);
    if (e.last) begin
      if (row_err[e.row] == 0) begin
        $display("Test %0d passed, nonce %h done", e.row, e.nonce);
        tests_ok++;
      end else begin
        $display("Test %0d failed with %0d errors", e.row, row_err[e.row]);
      end
    end
  endtask

  task automatic check_result(input result_t e);
    if (cyc != e.cyc) begin
      $display("Result for nonce %h came at cycle %0d instead of cycle %0d",
               e.nonce, cyc, e.cyc);
      note_error(e.row);
    end
    if (nonce_o !== e.nonce) begin
      $display("FAILED nonce_o: got %h, expected %h", nonce_o, e.nonce);
      note_error(e.row);
    end
    if (hash_newblock_o !== e.nb) begin
      $display("FAILED hash_newblock_o: got %h, expected %h", hash_newblock_o, e.nb);
      note_error(e.row);
    end
    if (e.chk && hash_o !== e.hash) begin
      $display("FAILED hash_o: got %h, expected %h", hash_o, e.hash);
      note_error(e.row);
    end
    close_row(e);
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
    if (cyc >= cycle_limit) begin
      $display("Timeout after %0d cycles, %0d results never arrived", cyc, exp_q.size());
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Outputs are sampled on the falling edge, half a cycle after they change.
  always @(negedge clk) begin
    if (arst_n_i === 1'b1) begin
      if (hash_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected result with nonce %h at cycle %0d", nonce_o, cyc);
          err_cnt++;
        end else begin
          head = exp_q.pop_front();
          check_result(head);
        end
      end else if (hash_valid_o !== 1'b0) begin
        $display("hash_valid_o is unknown at cycle %0d", cyc);
        err_cnt++;
      end else begin
        if (hash_newblock_o !== 1'b0) begin
          $display("hash_newblock_o set without hash_valid_o at cycle %0d", cyc);
          err_cnt++;
        end
        if (exp_q.size() != 0) begin
          head = exp_q[0];
          if (head.cyc == cyc) begin
            void'(exp_q.pop_front());
            $display("Result for nonce %h missing at cycle %0d", head.nonce, cyc);
            note_error(head.row);
            close_row(head);
          end
        end
      end
    end
  end

  initial begin
    int           gap;
    int           n_res;
    logic [255:0] mid;
    clk           = 1'b0;
    arst_n_i      = 1'b0;
    job_load_i    = 1'b0;
    midstate_i    = '0;
    merkle_tail_i = '0;
    time_i        = '0;
    bits_i        = '0;
    nonce_start_i = '0;
    nonce_count_i = '0;
    cyc           = '0;
    err_cnt       = 0;
    tests_ok      = 0;
    void'($urandom(32'hb13b_e8db));

    // Nonce and time words are the header bytes read big-endian.
    jobs[0] = {GEN_CHUNK, 32'h4b1e5e4a, 32'h29ab5f49, 32'hffff001d,
               32'h1dac2b7c, 32'd4, 32'd0, 32'd0, GEN_HASH};
    jobs[1] = {BLK1_CHUNK, 32'h57233e0e, 32'h61bc6649, 32'hffff001d,
               32'h01e36299, 32'd3, 32'd0, 32'd0, BLK1_HASH};
    jobs[2] = {GEN_CHUNK, 32'h4b1e5e4a, 32'h29ab5f49, 32'hffff001d,
               32'h1dac2b79, 32'd40, 32'd3, 32'd6, GEN_HASH}; // Cut by row 3.
    jobs[3] = {BLK1_CHUNK, 32'h57233e0e, 32'h61bc6649, 32'hffff001d,
               32'h01e36299, 32'd5, 32'd0, 32'd0, BLK1_HASH};

    cycle_limit = 2 + IDLE_CYCLES + 8 + 50 + N_ROWS * (LATENCY + MAX_GAP + 1);
    for (int r = 0; r < N_ROWS; r++) begin
      row_err[r]  = 0;
      cycle_limit = cycle_limit + jobs[r].count;
    end

    repeat (2) @(posedge clk);
    arst_n_i <= 1'b1;
    repeat (IDLE_CYCLES) @(posedge clk); // No results may appear before a load.

    for (int r = 0; r < N_ROWS; r++) begin
      mid = compress_chunk(IV, jobs[r].chunk);
      job_load_i    <= 1'b1;
      midstate_i    <= mid;
      merkle_tail_i <= jobs[r].tail;
      time_i        <= jobs[r].time_w;
      bits_i        <= jobs[r].bits;
      nonce_start_i <= jobs[r].start;
      nonce_count_i <= jobs[r].count;
      @(negedge clk);
      n_res = (jobs[r].reload != 0) ? jobs[r].reload : jobs[r].count;
      for (int k = 0; k < n_res; k++) begin
        expect_result(r, k, n_res, cyc);
      end
      @(posedge clk);
      job_load_i <= 1'b0;
      if (jobs[r].reload != 0) begin
        repeat (jobs[r].reload - 1) @(posedge clk);
      end else begin
        gap = $urandom % (MAX_GAP + 1);
        repeat (jobs[r].count + gap) @(posedge clk);
      end
    end

    while (exp_q.size() != 0) @(negedge clk);
    repeat (8) @(negedge clk); // Catch any stray result after the last job.
    $display("%0d of %0d tests passed, %0d errors", tests_ok, N_ROWS, err_cnt);
    if (err_cnt == 0 && tests_ok == N_ROWS) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_sha_miner

`default_nettype wire

// ==== src.f ====
verilog/sha_pkg.sv
verilog/sha_stage_if.sv
verilog/sha_round_stage.sv
verilog/sha_job_regs.sv
verilog/sha_state_delay.sv
verilog/sha_pad_hash.sv
verilog/sha_double_core.sv
verilog/sha_miner_top.sv
bench/sha_miner_props.sv
bench/tb_sha_miner.sv

// ==== Bender.yml ====
package:
  name: sha_miner

sources:
  - verilog/sha_pkg.sv
  - verilog/sha_stage_if.sv
  - verilog/sha_round_stage.sv
  - verilog/sha_job_regs.sv
  - verilog/sha_state_delay.sv
  - verilog/sha_pad_hash.sv
  - verilog/sha_double_core.sv
  - verilog/sha_miner_top.sv
  - target: test
    files:
      - bench/sha_miner_props.sv
      - bench/tb_sha_miner.sv
